//--- Bender.yml
package:
  name: id_stage

sources:
  - logic/id_pkg.sv
  - logic/id_ctrl_if.sv
  - logic/id_decoder.sv
  - logic/id_fwd_lane.sv
  - logic/id_ex_register.sv
  - logic/id_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/id_stage_tb.sv

//--- bench/id_stage_cases.txt
# name instr pc kill ex_we ex_load ex_waddr ex_wdata wb_we wb_waddr wb_wdata, then expected:
# alu_op op_a op_b op_c rf_we rd lsu_en lsu_we illegal jump jmp_target id_ready
add_rr 002081b3 00001000 0 0 0 00 00000000 0 00 00000000 0 10000101 10000202 00000000 1 03 0 0 0 0 00000000 1
sub_rr 407302b3 00001004 0 0 0 00 00000000 0 00 00000000 1 10000606 10000707 00000000 1 05 0 0 0 0 00000000 1
sltu_rr 00b534b3 00001008 0 0 0 00 00000000 0 00 00000000 9 10000a0a 10000b0b 00000000 1 09 0 0 0 0 00000000 1
addi_neg fff08213 0000100c 0 0 0 00 00000000 0 00 00000000 0 10000101 ffffffff 00000000 1 04 0 0 0 0 00000000 1
andi_mask 0f017313 00001010 0 0 0 00 00000000 0 00 00000000 4 10000202 000000f0 00000000 1 06 0 0 0 0 00000000 1
srai_shift 4041d393 00001014 0 0 0 00 00000000 0 00 00000000 7 10000303 00000404 00000000 1 07 0 0 0 0 00000000 1
lui_upper abcde537 00001018 0 0 0 00 00000000 0 00 00000000 0 00000000 abcde000 00000000 1 0a 0 0 0 0 00000000 1
auipc_pc 00012597 00002000 0 0 0 00 00000000 0 00 00000000 0 00002000 00012000 00000000 1 0b 0 0 0 0 00000000 1
fwd_ex_wins 002081b3 00002004 0 1 0 01 aaaa0001 1 01 bbbb0001 0 aaaa0001 10000202 00000000 1 03 0 0 0 0 00000000 1
fwd_wb_wins 002081b3 00002008 0 1 0 05 aaaa0005 1 02 bbbb0002 0 10000101 bbbb0002 00000000 1 03 0 0 0 0 00000000 1
fwd_x0_zero 002001b3 0000200c 0 1 0 00 aaaa0000 1 00 bbbb0000 0 00000000 10000202 00000000 1 03 0 0 0 0 00000000 1
load_use_add 002081b3 00002010 0 1 1 02 dead0002 0 00 00000000 0 10000101 10000202 00000000 1 03 0 0 0 0 00000000 0
load_use_lw 00832283 00002014 0 1 1 06 dead0006 0 00 00000000 0 10000606 00000008 00000000 1 05 1 0 0 0 00000000 0
jal_fwd 001000ef 00003000 0 0 0 00 00000000 0 00 00000000 0 00003000 00000004 00000000 1 01 0 0 0 1 00003800 1
jal_back_x0 ff1ff06f 00003100 0 0 0 00 00000000 0 00 00000000 0 00003100 00000004 00000000 0 00 0 0 0 1 000030f0 1
jalr_align 010280e7 00004000 0 0 0 00 00000000 0 00 00000000 0 00004000 00000004 00000000 1 01 0 0 0 1 10000514 1
jalr_fwd 00028067 00004100 0 1 0 05 20000003 0 00 00000000 0 00004100 00000004 00000000 0 00 0 0 0 1 20000002 1
beq_fwd 02208063 00005000 0 0 0 00 00000000 0 00 00000000 a 10000101 10000202 00005020 0 00 0 0 0 0 00005020 1
bltu_back fe41ece3 00005100 0 0 0 00 00000000 0 00 00000000 e 10000303 10000404 000050f8 0 19 0 0 0 0 000050f8 1
sw_store 00732623 00006000 0 0 0 00 00000000 0 00 00000000 0 10000606 0000000c 10000707 0 0c 1 1 0 0 00000000 1
ecall_illegal 00000073 00007000 0 0 0 00 00000000 0 00 00000000 0 00000000 00000000 00000000 0 00 0 0 1 0 00000000 1
mul_illegal 027302b3 00007004 0 0 0 00 00000000 0 00 00000000 0 10000606 10000707 00000000 0 05 0 0 1 0 00000000 1
kill_jal 001000ef 00008000 1 0 0 00 00000000 0 00 00000000 0 00000000 00000000 00000000 0 00 0 0 0 0 00000000 1

//--- bench/id_stage_checks.svh
`ifndef ID_STAGE_CHECKS_SVH
`define ID_STAGE_CHECKS_SVH

  ////////////////////////////////
  // Typed compares
  ////////////////////////////////

  // Operands, PCs and targets
  task automatic check_word(input name_t test, input string what,
                            input word_t exp, input word_t act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch in %0s %0s: expected %h, actual %h",
                               test, what, exp, act));
    end
  endtask

  // Destination register index
  task automatic check_addr(input name_t test, input string what,
                            input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch in %0s %0s: expected %0d, actual %0d",
                               test, what, exp, act));
    end
  endtask

  task automatic check_alu_op(input name_t test, input string what,
                              input alu_op_e exp, input alu_op_e act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch in %0s %0s: expected %0d, actual %0d",
                               test, what, exp, act));
    end
  endtask

  // Single control flags and handshake bits
  task automatic check_bit(input name_t test, input string what,
                           input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("Mismatch in %0s %0s: expected %b, actual %b",
                               test, what, exp, act));
    end
  endtask

`endif

//--- bench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
  import id_pkg::*;

  localparam int CLK_HALF    = 50;
  localparam int DRIVE_DELAY = 10;

  typedef logic [8*24-1:0] name_t;

  // One line of the cases file
  typedef struct packed {
    name_t     name;
    instr_t    instr;
    word_t     pc;
    logic      kill;
    logic      ex_we;
    logic      ex_load;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
    logic      rf_we;
    reg_addr_t rd;
    logic      lsu_en;
    logic      lsu_we;
    logic      illegal;
    logic      jump;
    word_t     target;
    logic      ready;
  } case_t;

  logic clk;
  logic rst_n;
  logic instr_valid_i;
  instr_t instr_i;
  word_t pc_i;
  logic kill_i;
  logic id_ready_o;
  logic [NUM_READ_PORTS-1:0] rf_re;
  reg_addr_t rf_raddr [NUM_READ_PORTS];
  word_t rf_rdata [NUM_READ_PORTS];
  logic ex_we_i;
  logic ex_load_i;
  reg_addr_t ex_waddr_i;
  word_t ex_wdata_i;
  logic wb_we_i;
  reg_addr_t wb_waddr_i;
  word_t wb_wdata_i;
  logic ex_ready_i;
  logic ex_valid_o;
  alu_op_e ex_alu_op_o;
  word_t ex_operand_a_o;
  word_t ex_operand_b_o;
  word_t ex_operand_c_o;
  logic ex_rf_we_o;
  reg_addr_t ex_rd_o;
  logic ex_lsu_en_o;
  logic ex_lsu_we_o;
  logic ex_illegal_o;
  word_t ex_pc_o;
  logic jump_o;
  word_t jmp_target_o;

  case_t cases [$];
  int unsigned seed;
  int cycle_count = 0;
  int cycle_limit = 0;

  // ID/EX state captured before a back-pressure window
  logic snap_valid;
  alu_op_e snap_alu_op;
  word_t snap_a;
  word_t snap_b;
  word_t snap_c;
  logic snap_rf_we;
  reg_addr_t snap_rd;
  logic snap_lsu_en;
  logic snap_lsu_we;
  logic snap_illegal;
  word_t snap_pc;

  id_stage id_stage_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .kill_i         (kill_i),
    .id_ready_o     (id_ready_o),
    .rf_re_o        (rf_re),
    .rf_raddr_o     (rf_raddr),
    .rf_rdata_i     (rf_rdata),
    .ex_we_i        (ex_we_i),
    .ex_load_i      (ex_load_i),
    .ex_waddr_i     (ex_waddr_i),
    .ex_wdata_i     (ex_wdata_i),
    .wb_we_i        (wb_we_i),
    .wb_waddr_i     (wb_waddr_i),
    .wb_wdata_i     (wb_wdata_i),
    .ex_ready_i     (ex_ready_i),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rd_o        (ex_rd_o),
    .ex_lsu_en_o    (ex_lsu_en_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_pc_o        (ex_pc_o),
    .jump_o         (jump_o),
    .jmp_target_o   (jmp_target_o)
  );

  task automatic report_failure(input string msg);
    $display("%0s", msg);
    $display("Test FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  `include "id_stage_checks.svh"

  // Register file contents follow the address, x0 reads zero
  function automatic word_t rf_value(input reg_addr_t r);
    if (r == '0) begin
      return '0;
    end
    return 32'h1000_0000 + r * 32'h0000_0101;
  endfunction

  // Source registers read by each RV32I opcode, rs1 in bit 0
  function automatic logic [NUM_READ_PORTS-1:0] source_reads(input instr_t instr);
    case (instr[6:0])
      OPC_JALR, OPC_LOAD, OPC_OP_IMM: return 2'b01;
      OPC_BRANCH, OPC_STORE, OPC_OP:  return 2'b11;
      default:                        return 2'b00;
    endcase
  endfunction

  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : gen_rf_model
    assign rf_rdata[p] = rf_value(rf_raddr[p]);
  end

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      report_failure($sformatf("Timeout after %0d cycles without finishing the cases",
                               cycle_count));
    end
  end

  ////////////////////////////////
  // Cases file
  ////////////////////////////////

  task automatic read_cases();
    int fd;
    int cnt;
    logic [8*256-1:0] line;
    name_t tok;
    logic [31:0] fld [22];
    case_t c;
    fd = $fopen("bench/id_stage_cases.txt", "r");
    if (fd == 0) begin
      report_failure("Cannot open bench/id_stage_cases.txt");
    end
    line = '0;
    while ($fgets(line, fd) != 0) begin
      tok = '0;
      cnt = $sscanf(line, "%s", tok);
      // Skip blank and comment lines
      if (cnt == 1 && tok != "#") begin
        cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      tok, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                      fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15],
                      fld[16], fld[17], fld[18], fld[19], fld[20], fld[21]);
        if (cnt != 23) begin
          report_failure($sformatf("Malformed line in cases file: %0s", line));
        end
        c.name     = tok;
        c.instr    = fld[0];
        c.pc       = fld[1];
        c.kill     = fld[2][0];
        c.ex_we    = fld[3][0];
        c.ex_load  = fld[4][0];
        c.ex_waddr = fld[5][4:0];
        c.ex_wdata = fld[6];
        c.wb_we    = fld[7][0];
        c.wb_waddr = fld[8][4:0];
        c.wb_wdata = fld[9];
        c.alu_op   = alu_op_e'(fld[10][3:0]);
        c.op_a     = fld[11];
        c.op_b     = fld[12];
        c.op_c     = fld[13];
        c.rf_we    = fld[14][0];
        c.rd       = fld[15][4:0];
        c.lsu_en   = fld[16][0];
        c.lsu_we   = fld[17][0];
        c.illegal  = fld[18][0];
        c.jump     = fld[19][0];
        c.target   = fld[20];
        c.ready    = fld[21][0];
        cases.push_back(c);
      end
      line = '0;
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      report_failure("Cases file holds no test lines");
    end
  endtask

  ////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////

  task automatic drive_case(input case_t c, input logic ready);
    instr_valid_i = 1'b1;
    instr_i       = c.instr;
    pc_i          = c.pc;
    kill_i        = c.kill;
    ex_we_i       = c.ex_we;
    ex_load_i     = c.ex_load;
    ex_waddr_i    = c.ex_waddr;
    ex_wdata_i    = c.ex_wdata;
    wb_we_i       = c.wb_we;
    wb_waddr_i    = c.wb_waddr;
    wb_wdata_i    = c.wb_wdata;
    ex_ready_i    = ready;
  endtask

  // Older producers have retired
  task automatic clear_fwd_fields();
    ex_we_i   = 1'b0;
    ex_load_i = 1'b0;
    wb_we_i   = 1'b0;
  endtask

  task automatic take_snapshot();
    snap_valid   = ex_valid_o;
    snap_alu_op  = ex_alu_op_o;
    snap_a       = ex_operand_a_o;
    snap_b       = ex_operand_b_o;
    snap_c       = ex_operand_c_o;
    snap_rf_we   = ex_rf_we_o;
    snap_rd      = ex_rd_o;
    snap_lsu_en  = ex_lsu_en_o;
    snap_lsu_we  = ex_lsu_we_o;
    snap_illegal = ex_illegal_o;
    snap_pc      = ex_pc_o;
  endtask

  task automatic check_hold(input name_t test);
    check_bit(test, "ex_valid_o hold", snap_valid, ex_valid_o);
    check_alu_op(test, "ex_alu_op_o hold", snap_alu_op, ex_alu_op_o);
    check_word(test, "ex_operand_a_o hold", snap_a, ex_operand_a_o);
    check_word(test, "ex_operand_b_o hold", snap_b, ex_operand_b_o);
    check_word(test, "ex_operand_c_o hold", snap_c, ex_operand_c_o);
    check_bit(test, "ex_rf_we_o hold", snap_rf_we, ex_rf_we_o);
    check_addr(test, "ex_rd_o hold", snap_rd, ex_rd_o);
    check_bit(test, "ex_lsu_en_o hold", snap_lsu_en, ex_lsu_en_o);
    check_bit(test, "ex_lsu_we_o hold", snap_lsu_we, ex_lsu_we_o);
    check_bit(test, "ex_illegal_o hold", snap_illegal, ex_illegal_o);
    check_word(test, "ex_pc_o hold", snap_pc, ex_pc_o);
  endtask

  task automatic check_outputs(input case_t c);
    check_bit(c.name, "ex_valid_o", 1'b1, ex_valid_o);
    check_alu_op(c.name, "ex_alu_op_o", c.alu_op, ex_alu_op_o);
    check_word(c.name, "ex_operand_a_o", c.op_a, ex_operand_a_o);
    check_word(c.name, "ex_operand_b_o", c.op_b, ex_operand_b_o);
    check_word(c.name, "ex_operand_c_o", c.op_c, ex_operand_c_o);
    check_bit(c.name, "ex_rf_we_o", c.rf_we, ex_rf_we_o);
    check_addr(c.name, "ex_rd_o", c.rd, ex_rd_o);
    check_bit(c.name, "ex_lsu_en_o", c.lsu_en, ex_lsu_en_o);
    check_bit(c.name, "ex_lsu_we_o", c.lsu_we, ex_lsu_we_o);
    check_bit(c.name, "ex_illegal_o", c.illegal, ex_illegal_o);
    check_word(c.name, "ex_pc_o", c.pc, ex_pc_o);
  endtask

  task automatic run_case(input case_t c);
    int unsigned hold_cycles;
    int unsigned stall_cycles;
    logic [NUM_READ_PORTS-1:0] exp_re;
    hold_cycles  = $urandom % 4;
    stall_cycles = 0;
    take_snapshot();
    drive_case(c, hold_cycles == 0);
    // EX not ready so the ID/EX register must not move
    repeat (hold_cycles) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_hold(c.name);
    end
    ex_ready_i = 1'b1;
    #1;
    // Combinational view of the instruction in ID
    check_bit(c.name, "id_ready_o", c.ready, id_ready_o);
    check_bit(c.name, "jump_o", c.jump, jump_o);
    if (!c.kill && (c.jump || c.alu_op >= ALU_EQ)) begin
      check_word(c.name, "jmp_target_o", c.target, jmp_target_o);
    end
    // Read enables only follow the opcode for legal words
    if (!c.illegal) begin
      exp_re = source_reads(c.instr);
      check_bit(c.name, "rf_re_o[0]", exp_re[0], rf_re[0]);
      check_bit(c.name, "rf_re_o[1]", exp_re[1], rf_re[1]);
    end
    // Load-use stall until the EX fields clear
    while (!id_ready_o) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_bit(c.name, "ex_valid_o during stall", 1'b0, ex_valid_o);
      stall_cycles++;
      if (stall_cycles == 2) begin
        clear_fwd_fields();
      end
      #1;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    if (c.kill) begin
      check_bit(c.name, "ex_valid_o after kill", 1'b0, ex_valid_o);
    end else begin
      check_outputs(c);
    end
  endtask

  ////////////////////////////////
  // Main sequence
  ////////////////////////////////

  initial begin
    seed          = $urandom(32'h55a7);
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    kill_i        = 1'b0;
    ex_we_i       = 1'b0;
    ex_load_i     = 1'b0;
    ex_waddr_i    = '0;
    ex_wdata_i    = '0;
    wb_we_i       = 1'b0;
    wb_waddr_i    = '0;
    wb_wdata_i    = '0;
    ex_ready_i    = 1'b1;
    read_cases();
    cycle_limit = cases.size() * 10 + 20;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    for (int i = 0; i < cases.size(); i++) begin
      run_case(cases[i]);
    end
    instr_valid_i = 1'b0;
    $display("Test OK");
    $finish;
  end

endmodule

//--- id_stage.f
+incdir+bench
logic/id_pkg.sv
logic/id_ctrl_if.sv
logic/id_decoder.sv
logic/id_fwd_lane.sv
logic/id_ex_register.sv
logic/id_stage.sv
bench/id_stage_tb.sv

//--- logic/id_ctrl_if.sv
`timescale 1ns/1ps

// Decoded control set for the instruction currently in ID
interface id_ctrl_if;
  import id_pkg::*;

  alu_op_e   alu_op;
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  op_c_sel_e op_c_sel;
  imm_sel_e  imm_sel;
  xfer_e     xfer;
  logic      rf_we;
  reg_addr_t rd;
  logic      lsu_en;
  logic      lsu_we;
  logic      illegal;

  // Decoder side
  modport dec (output alu_op, op_a_sel, op_b_sel, op_c_sel, imm_sel, xfer,
               output rf_we, rd, lsu_en, lsu_we, illegal);
  // ID/EX register side
  modport regs (input alu_op, op_a_sel, op_b_sel, op_c_sel, imm_sel, xfer,
                input rf_we, rd, lsu_en, lsu_we, illegal);

endinterface

//--- logic/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
  input  id_pkg::instr_t                   instr_i,
  id_ctrl_if.dec                           ctrl,
  output id_pkg::reg_addr_t                rs_addr_o [id_pkg::NUM_READ_PORTS],
  output logic [id_pkg::NUM_READ_PORTS-1:0] rs_re_o
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Raw decode before the illegal and x0 qualifiers
  logic                      illegal;
  logic                      rf_we_dec;
  logic                      lsu_en_dec;
  logic                      lsu_we_dec;
  logic [NUM_READ_PORTS-1:0] rs_re_dec;
  xfer_e                     xfer_dec;

  // Register-register and register-immediate ops share the funct3 map
  function automatic alu_op_e base_alu_op(input logic [2:0] f3);
    case (f3)
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      3'b111:  return ALU_AND;
      default: return ALU_ADD;
    endcase
  endfunction

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Register fields are read speculatively
  assign rs_addr_o[0] = instr_i[RS1_MSB:RS1_LSB];
  assign rs_addr_o[1] = instr_i[RS2_MSB:RS2_LSB];
  assign ctrl.rd      = instr_i[RD_MSB:RD_LSB];

  always_comb begin
    ctrl.alu_op   = ALU_ADD;
    ctrl.op_a_sel = OP_A_REG;
    ctrl.op_b_sel = OP_B_REG;
    ctrl.op_c_sel = OP_C_ZERO;
    ctrl.imm_sel  = IMM_I;
    xfer_dec      = XFER_NONE;
    rf_we_dec     = 1'b0;
    lsu_en_dec    = 1'b0;
    lsu_we_dec    = 1'b0;
    rs_re_dec     = '0;
    illegal       = 1'b0;

    case (opcode)
      OPC_LUI: begin
        ctrl.op_a_sel = OP_A_ZERO;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
        rf_we_dec     = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
        rf_we_dec     = 1'b1;
      end
      // Link value is PC + 4
      OPC_JAL, OPC_JALR: begin
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_PCINC;
        rf_we_dec     = 1'b1;
        xfer_dec      = (opcode == OPC_JAL) ? XFER_JAL : XFER_JALR;
        rs_re_dec[0]  = (opcode == OPC_JALR);
        illegal       = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.op_c_sel = OP_C_BCH;
        xfer_dec      = XFER_BRANCH;
        rs_re_dec     = 2'b11;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      // LB LH LW LBU LHU only
      OPC_LOAD: begin
        ctrl.op_b_sel = OP_B_IMM;
        rs_re_dec[0]  = 1'b1;
        rf_we_dec     = 1'b1;
        lsu_en_dec    = 1'b1;
        illegal       = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.op_c_sel = OP_C_RS2;
        ctrl.imm_sel  = IMM_S;
        rs_re_dec     = 2'b11;
        lsu_en_dec    = 1'b1;
        lsu_we_dec    = 1'b1;
        illegal       = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OP_IMM: begin
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.alu_op   = base_alu_op(funct3);
        rs_re_dec[0]  = 1'b1;
        rf_we_dec     = 1'b1;
        // Shift amount encodings carry funct7
        if (funct3 == 3'b001) begin
          illegal = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'h20) begin
            ctrl.alu_op = ALU_SRA;
          end else begin
            illegal = (funct7 != 7'h00);
          end
        end
      end
      OPC_OP: begin
        ctrl.alu_op = base_alu_op(funct3);
        rs_re_dec   = 2'b11;
        rf_we_dec   = 1'b1;
        if (funct7 == 7'h20) begin
          case (funct3)
            3'b000:  ctrl.alu_op = ALU_SUB;
            3'b101:  ctrl.alu_op = ALU_SRA;
            default: illegal = 1'b1;
          endcase
        end else if (funct7 != 7'h00) begin
          illegal = 1'b1;
        end
      end
      // SYSTEM, FENCE and anything else
      default: illegal = 1'b1;
    endcase
  end

  // Illegal encodings have no side effects downstream
  assign ctrl.illegal = illegal;
  assign ctrl.xfer    = illegal ? XFER_NONE : xfer_dec;
  assign ctrl.rf_we   = rf_we_dec && !illegal && (ctrl.rd != '0);
  assign ctrl.lsu_en  = lsu_en_dec && !illegal;
  assign ctrl.lsu_we  = lsu_we_dec && !illegal;
  // No reads for illegal words, so they never stall
  assign rs_re_o      = illegal ? '0 : rs_re_dec;

endmodule

//--- logic/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register (
  input  logic              clk,
  input  logic              rst_n,
  id_ctrl_if.regs           ctrl,
  input  id_pkg::instr_t    instr_i,
  input  id_pkg::word_t     pc_i,
  input  logic              instr_valid_i,
  input  logic              kill_i,
  input  logic              ex_ready_i,
  input  id_pkg::word_t     operand_i [id_pkg::NUM_READ_PORTS],
  input  logic              stall_i,
  output logic              id_ready_o,
  output logic              jump_o,
  output id_pkg::word_t     jmp_target_o,
  output logic              ex_valid_o,
  output id_pkg::alu_op_e   ex_alu_op_o,
  output id_pkg::word_t     ex_operand_a_o,
  output id_pkg::word_t     ex_operand_b_o,
  output id_pkg::word_t     ex_operand_c_o,
  output logic              ex_rf_we_o,
  output id_pkg::reg_addr_t ex_rd_o,
  output logic              ex_lsu_en_o,
  output logic              ex_lsu_we_o,
  output logic              ex_illegal_o,
  output id_pkg::word_t     ex_pc_o
);
  import id_pkg::*;

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_u_type;
  word_t imm_b_type;
  word_t imm_j_type;
  word_t imm_sel_val;

  word_t operand_a;
  word_t operand_b;
  word_t operand_c;

  word_t bch_target;
  word_t jal_target;
  word_t jalr_sum;
  word_t jalr_target;

  logic  instr_live;
  logic  fire;

  ////////////////////////////////
  // Immediates
  ////////////////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u_type = {instr_i[31:12], 12'h000};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  always_comb begin
    case (ctrl.imm_sel)
      IMM_S:   imm_sel_val = imm_s_type;
      IMM_U:   imm_sel_val = imm_u_type;
      default: imm_sel_val = imm_i_type;
    endcase
  end

  ////////////////////////////////
  // Operand muxes
  ////////////////////////////////

  always_comb begin
    case (ctrl.op_a_sel)
      OP_A_PC:   operand_a = pc_i;
      OP_A_ZERO: operand_a = '0;
      default:   operand_a = operand_i[0];
    endcase
  end

  always_comb begin
    case (ctrl.op_b_sel)
      OP_B_IMM:   operand_b = imm_sel_val;
      OP_B_PCINC: operand_b = 32'd4;
      default:    operand_b = operand_i[1];
    endcase
  end

  // Branch target rides on C so EX only compares
  always_comb begin
    case (ctrl.op_c_sel)
      OP_C_RS2: operand_c = operand_i[1];
      OP_C_BCH: operand_c = bch_target;
      default:  operand_c = '0;
    endcase
  end

  ////////////////////////////////
  // Jump targets
  ////////////////////////////////

  assign bch_target = pc_i + imm_b_type;
  assign jal_target = pc_i + imm_j_type;
  // JALR base comes through the rs1 forwarding lane
  assign jalr_sum    = operand_i[0] + imm_i_type;
  assign jalr_target = {jalr_sum[31:1], 1'b0};

  always_comb begin
    case (ctrl.xfer)
      XFER_JALR:   jmp_target_o = jalr_target;
      XFER_BRANCH: jmp_target_o = bch_target;
      default:     jmp_target_o = jal_target;
    endcase
  end

  assign instr_live = instr_valid_i && !kill_i;
  assign jump_o     = instr_live && ((ctrl.xfer == XFER_JAL) || (ctrl.xfer == XFER_JALR));

  ////////////////////////////////
  // Handshake and ID/EX register
  ////////////////////////////////

  // A killed instruction leaves ID without waiting
  assign id_ready_o = kill_i || (ex_ready_i && !stall_i);
  assign fire       = instr_live && !stall_i && ex_ready_i;

  // Control bits drop to zero for bubbles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid_o   <= 1'b0;
      ex_rf_we_o   <= 1'b0;
      ex_lsu_en_o  <= 1'b0;
      ex_lsu_we_o  <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else if (ex_ready_i) begin
      ex_valid_o   <= fire;
      ex_rf_we_o   <= fire && ctrl.rf_we;
      ex_lsu_en_o  <= fire && ctrl.lsu_en;
      ex_lsu_we_o  <= fire && ctrl.lsu_we;
      ex_illegal_o <= fire && ctrl.illegal;
    end
  end

  // Payload only loads on an accepted instruction
  always_ff @(posedge clk) begin
    if (fire) begin
      ex_alu_op_o    <= ctrl.alu_op;
      ex_operand_a_o <= operand_a;
      ex_operand_b_o <= operand_b;
      ex_operand_c_o <= operand_c;
      ex_rd_o        <= ctrl.rd;
      ex_pc_o        <= pc_i;
    end
  end

  a_hold_under_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_o && !ex_ready_i) |=> $stable({ex_valid_o, ex_alu_op_o, ex_operand_a_o,
      ex_operand_b_o, ex_operand_c_o, ex_rf_we_o, ex_rd_o, ex_lsu_en_o, ex_lsu_we_o,
      ex_illegal_o, ex_pc_o}))
    else $error("ID/EX outputs changed while EX was not ready");

endmodule

//--- logic/id_fwd_lane.sv
`timescale 1ns/1ps

module id_fwd_lane (
  input  logic              clk,
  input  logic              rst_n,
  input  id_pkg::reg_addr_t rs_addr_i,
  input  logic              rs_re_i,
  input  id_pkg::word_t     rf_rdata_i,
  input  logic              ex_we_i,
  input  logic              ex_load_i,
  input  id_pkg::reg_addr_t ex_waddr_i,
  input  id_pkg::word_t     ex_wdata_i,
  input  logic              wb_we_i,
  input  id_pkg::reg_addr_t wb_waddr_i,
  input  id_pkg::word_t     wb_wdata_i,
  output id_pkg::word_t     operand_o,
  output logic              stall_o
);

  typedef enum logic [1:0] {FWD_RF, FWD_EX, FWD_WB} fwd_src_e;

  logic     rs_live;
  logic     ex_hit;
  logic     wb_hit;
  fwd_src_e fwd_src;

  // x0 and unused sources always take the register file
  assign rs_live = rs_re_i && (rs_addr_i != '0);
  assign ex_hit  = rs_live && ex_we_i && (ex_waddr_i == rs_addr_i);
  assign wb_hit  = rs_live && wb_we_i && (wb_waddr_i == rs_addr_i);

  // Load data is not ready in EX yet
  assign stall_o = ex_hit && ex_load_i;

  // Youngest producer wins
  always_comb begin
    if (ex_hit && !ex_load_i) begin
      fwd_src = FWD_EX;
    end else if (wb_hit) begin
      fwd_src = FWD_WB;
    end else begin
      fwd_src = FWD_RF;
    end
  end

  always_comb begin
    case (fwd_src)
      FWD_EX:  operand_o = ex_wdata_i;
      FWD_WB:  operand_o = wb_wdata_i;
      default: operand_o = rf_rdata_i;
    endcase
  end

  // While stalled the operand falls back to WB or the register file
  a_no_ex_fwd_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall_o |-> (operand_o == (wb_hit ? wb_wdata_i : rf_rdata_i)))
    else $error("Operand forwarded from EX during load-use stall");

endmodule

//--- logic/id_pkg.sv
package id_pkg;

  ////////////////////////////////
  // Basic widths
  ////////////////////////////////

  // Data word, operand or PC
  typedef logic [31:0] word_t;
  // Raw instruction word as fetched
  typedef logic [31:0] instr_t;
  // Index into the 32-entry register file
  typedef logic [4:0]  reg_addr_t;

  // Source lanes, rs1 and rs2
  localparam int unsigned NUM_READ_PORTS = 2;

  // Register field positions in the instruction word
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS1_MSB = 19;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned RS2_MSB = 24;
  localparam int unsigned RD_LSB  = 7;
  localparam int unsigned RD_MSB  = 11;

  ////////////////////////////////
  // RV32I base opcodes
  ////////////////////////////////

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  ////////////////////////////////
  // Control encodings
  ////////////////////////////////

  // Arithmetic ops first, then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;

  // PCINC is the link value for JAL and JALR
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINC} op_b_sel_e;

  // Store data or branch target travel on operand C
  typedef enum logic [1:0] {OP_C_RS2, OP_C_BCH, OP_C_ZERO} op_c_sel_e;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_sel_e;

  // Control transfer class of the instruction
  typedef enum logic [1:0] {XFER_NONE, XFER_JAL, XFER_JALR, XFER_BRANCH} xfer_e;

endpackage

//--- logic/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  // Instruction from IF
  input  logic                              instr_valid_i,
  input  id_pkg::instr_t                    instr_i,
  input  id_pkg::word_t                     pc_i,
  input  logic                              kill_i,
  output logic                              id_ready_o,
  // Register file read ports
  output logic [id_pkg::NUM_READ_PORTS-1:0] rf_re_o,
  output id_pkg::reg_addr_t                 rf_raddr_o [id_pkg::NUM_READ_PORTS],
  input  id_pkg::word_t                     rf_rdata_i [id_pkg::NUM_READ_PORTS],
  // EX and WB writeback for forwarding
  input  logic                              ex_we_i,
  input  logic                              ex_load_i,
  input  id_pkg::reg_addr_t                 ex_waddr_i,
  input  id_pkg::word_t                     ex_wdata_i,
  input  logic                              wb_we_i,
  input  id_pkg::reg_addr_t                 wb_waddr_i,
  input  id_pkg::word_t                     wb_wdata_i,
  input  logic                              ex_ready_i,
  // ID/EX pipeline outputs
  output logic                              ex_valid_o,
  output id_pkg::alu_op_e                   ex_alu_op_o,
  output id_pkg::word_t                     ex_operand_a_o,
  output id_pkg::word_t                     ex_operand_b_o,
  output id_pkg::word_t                     ex_operand_c_o,
  output logic                              ex_rf_we_o,
  output id_pkg::reg_addr_t                 ex_rd_o,
  output logic                              ex_lsu_en_o,
  output logic                              ex_lsu_we_o,
  output logic                              ex_illegal_o,
  output id_pkg::word_t                     ex_pc_o,
  // Jumps resolved in ID
  output logic                              jump_o,
  output id_pkg::word_t                     jmp_target_o
);
  import id_pkg::*;

  id_ctrl_if ctrl_if ();

  word_t                     operand_fw [NUM_READ_PORTS];
  logic [NUM_READ_PORTS-1:0] lane_stall;
  logic                      stall;

  id_decoder id_decoder_inst (
    .instr_i   (instr_i),
    .ctrl      (ctrl_if.dec),
    .rs_addr_o (rf_raddr_o),
    .rs_re_o   (rf_re_o)
  );

  // One forwarding lane per source register
  for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : gen_fwd_lane
    id_fwd_lane id_fwd_lane_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .rs_addr_i  (rf_raddr_o[i]),
      .rs_re_i    (rf_re_o[i]),
      .rf_rdata_i (rf_rdata_i[i]),
      .ex_we_i    (ex_we_i),
      .ex_load_i  (ex_load_i),
      .ex_waddr_i (ex_waddr_i),
      .ex_wdata_i (ex_wdata_i),
      .wb_we_i    (wb_we_i),
      .wb_waddr_i (wb_waddr_i),
      .wb_wdata_i (wb_wdata_i),
      .operand_o  (operand_fw[i]),
      .stall_o    (lane_stall[i])
    );
  end

  // Either lane waiting on a load holds the stage
  assign stall = |lane_stall;

  id_ex_register id_ex_register_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl           (ctrl_if.regs),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .instr_valid_i  (instr_valid_i),
    .kill_i         (kill_i),
    .ex_ready_i     (ex_ready_i),
    .operand_i      (operand_fw),
    .stall_i        (stall),
    .id_ready_o     (id_ready_o),
    .jump_o         (jump_o),
    .jmp_target_o   (jmp_target_o),
    .ex_valid_o     (ex_valid_o),
    .ex_alu_op_o    (ex_alu_op_o),
    .ex_operand_a_o (ex_operand_a_o),
    .ex_operand_b_o (ex_operand_b_o),
    .ex_operand_c_o (ex_operand_c_o),
    .ex_rf_we_o     (ex_rf_we_o),
    .ex_rd_o        (ex_rd_o),
    .ex_lsu_en_o    (ex_lsu_en_o),
    .ex_lsu_we_o    (ex_lsu_we_o),
    .ex_illegal_o   (ex_illegal_o),
    .ex_pc_o        (ex_pc_o)
  );

endmodule
